/* vlog.f */
+incdir+hw
hw/xcr_ctrl_pkg.sv
hw/xcr_data_pkg.sv
hw/xcr_fsm.sv
hw/word_reader.sv
hw/mix_engine.sv
hw/word_writer.sv
hw/xcr_top.sv
verification/xcr_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module xcr_tb -f vlog.f -o xcr_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/xcr_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
exit 1

/* verification/xcr_tb.sv */
`timescale 1ns/1ps
`include "xcr_settings.svh"

module xcr_tb;

  localparam int ROWS           = 6;
  localparam int BLOCK_W        = `XCR_BLOCK_WORDS * `XCR_WORD_W;
  localparam int TIMEOUT_CYCLES = ROWS * 64;

  logic                 clk = 1'b0;
  logic                 reset_n;
  logic                 start_i;
  xcr_data_pkg::addr_t  src_addr_i;
  xcr_data_pkg::addr_t  dst_addr_i;
  xcr_data_pkg::key_t   key_i;
  xcr_data_pkg::word_t  rd_data_i;
  logic                 done_o;
  logic                 rd_req_o;
  logic                 wr_en_o;
  xcr_data_pkg::addr_t  rd_addr_o;
  xcr_data_pkg::addr_t  wr_addr_o;
  xcr_data_pkg::word_t  wr_data_o;

  // Stimulus table with one job per row
  xcr_data_pkg::addr_t  tbl_src     [ROWS];
  xcr_data_pkg::addr_t  tbl_dst     [ROWS];
  xcr_data_pkg::key_t   tbl_key     [ROWS];
  xcr_data_pkg::block_t tbl_pt      [ROWS];
  logic                 tbl_restart [ROWS];

  xcr_data_pkg::word_t  mem      [xcr_data_pkg::addr_t];
  int                   rd_count [xcr_data_pkg::addr_t];
  int                   wr_count [xcr_data_pkg::addr_t];
  int                   rd_job_cnt;
  int                   wr_job_cnt;
  int                   rd_total;
  int                   wr_total;
  int                   done_total;
  int                   error_cnt;
  int                   cycle_cnt;

  xcr_top uut (
    .clk        (clk),
    .reset_n    (reset_n),
    .start_i    (start_i),
    .src_addr_i (src_addr_i),
    .dst_addr_i (dst_addr_i),
    .key_i      (key_i),
    .rd_data_i  (rd_data_i),
    .done_o     (done_o),
    .rd_req_o   (rd_req_o),
    .wr_en_o    (wr_en_o),
    .rd_addr_o  (rd_addr_o),
    .wr_addr_o  (wr_addr_o),
    .wr_data_o  (wr_data_o)
  );

  always #2 clk = ~clk;

  task automatic flag_error(input string msg);
    error_cnt++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  // Each round applies a key XOR and a one-bit left rotate of the block
  function automatic xcr_data_pkg::block_t ref_mix(
    input xcr_data_pkg::block_t pt,
    input xcr_data_pkg::key_t   key
  );
    logic [BLOCK_W-1:0] v;
    v = pt;
    for (int r = 0; r < `XCR_ROUNDS; r++) begin
      v = v ^ key;
      v = (v << 1) | (v >> (BLOCK_W - 1));
    end
    return v;
  endfunction

  task automatic fill_table();
    tbl_src[0] = 32'h0000_0100;
    tbl_dst[0] = 32'h0000_0200;
    tbl_key[0] = '0;
    tbl_pt[0]  = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    tbl_src[1] = 32'h0000_0300;
    tbl_dst[1] = 32'h0000_0400;
    tbl_key[1] = 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0;
    tbl_pt[1]  = '1;
    for (int r = 2; r < 4; r++) begin
      tbl_src[r] = 32'h0000_1000 + ($urandom & 32'h0000_0ff0);
      tbl_dst[r] = 32'h0000_2000 + ($urandom & 32'h0000_0ff0);
      tbl_key[r] = {$urandom, $urandom, $urandom, $urandom};
      tbl_pt[r]  = {$urandom, $urandom, $urandom, $urandom};
    end
    // Rows 4 and 5 overlap their source and destination windows
    tbl_src[4] = 32'h0000_0500;
    tbl_dst[4] = 32'h0000_0508;
    tbl_key[4] = 128'hdead_beef_0bad_f00d_cafe_babe_1357_9bdf;
    tbl_pt[4]  = 128'h8000_0001_7fff_fffe_5555_aaaa_0000_ffff;
    tbl_src[5] = 32'h0000_0508;
    tbl_dst[5] = 32'h0000_0500;
    tbl_key[5] = 128'h1111_2222_3333_4444_5555_6666_7777_8888;
    tbl_pt[5]  = 128'hffff_0000_a5a5_5a5a_c3c3_3c3c_0f0f_f0f0;
    for (int r = 0; r < ROWS; r++)
      tbl_restart[r] = (r == 4);
  endtask

  // Expects to be called just after a rising edge with the DUT idle
  task automatic run_job(input int row);
    xcr_data_pkg::block_t exp_blk;
    xcr_data_pkg::addr_t  a;
    for (int k = 0; k < `XCR_BLOCK_WORDS; k++)
      mem[tbl_src[row] + 4 * k] = tbl_pt[row][k];
    rd_count.delete();
    wr_count.delete();
    rd_job_cnt = 0;
    wr_job_cnt = 0;
    exp_blk = ref_mix(tbl_pt[row], tbl_key[row]);
    src_addr_i <= tbl_src[row];
    dst_addr_i <= tbl_dst[row];
    key_i      <= tbl_key[row];
    start_i    <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    if (tbl_restart[row]) begin
      // Second start in mid job must be ignored
      repeat (3) @(posedge clk);
      start_i <= 1'b1;
      @(posedge clk);
      start_i <= 1'b0;
    end
    do begin
      @(posedge clk);
    end while (!done_o);
    assert (rd_job_cnt == `XCR_BLOCK_WORDS && wr_job_cnt == `XCR_BLOCK_WORDS)
      else flag_error($sformatf("row %0d: %0d reads, %0d writes before done",
                                row, rd_job_cnt, wr_job_cnt));
    for (int k = 0; k < `XCR_BLOCK_WORDS; k++) begin
      a = tbl_src[row] + 4 * k;
      assert (rd_count.exists(a) && rd_count[a] == 1)
        else flag_error($sformatf("row %0d: source word %h not read exactly once", row, a));
      a = tbl_dst[row] + 4 * k;
      assert (wr_count.exists(a) && wr_count[a] == 1)
        else flag_error($sformatf("row %0d: dest word %h not written exactly once", row, a));
      assert (mem[a] === exp_blk[k])
        else flag_error($sformatf("row %0d word %0d at %h: got %h, expected %h",
                                  row, k, a, mem[a], exp_blk[k]));
    end
  endtask

  // Memory model with one cycle read latency and traffic counters
  always @(posedge clk) begin
    if (rd_req_o) begin
      rd_data_i <= mem.exists(rd_addr_o) ? mem[rd_addr_o] : ~rd_addr_o;
      rd_count[rd_addr_o] = rd_count.exists(rd_addr_o) ? rd_count[rd_addr_o] + 1 : 1;
      rd_job_cnt++;
      rd_total++;
    end
    if (wr_en_o) begin
      assert ((wr_addr_o - dst_addr_i) < 32'd16 && wr_addr_o[1:0] == 2'b00)
        else flag_error($sformatf("write to %h outside destination %h", wr_addr_o, dst_addr_i));
      mem[wr_addr_o] = wr_data_o;
      wr_count[wr_addr_o] = wr_count.exists(wr_addr_o) ? wr_count[wr_addr_o] + 1 : 1;
      wr_job_cnt++;
      wr_total++;
    end
    if (done_o)
      done_total++;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: jobs did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors: %0d", error_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(88));
    reset_n    = 1'b0;
    start_i    = 1'b0;
    src_addr_i = '0;
    dst_addr_i = '0;
    key_i      = '0;
    rd_data_i  = '0;
    rd_total   = 0;
    wr_total   = 0;
    done_total = 0;
    error_cnt  = 0;
    cycle_cnt  = 0;
    fill_table();
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    // Quiet outputs before the first start
    repeat (4) begin
      @(posedge clk);
      assert (!done_o && !rd_req_o && !wr_en_o)
        else flag_error("done, read or write active before the first start");
    end
    for (int r = 0; r < ROWS; r++)
      run_job(r);
    repeat (20) @(posedge clk);
    assert (done_total == ROWS)
      else flag_error($sformatf("%0d done pulses for %0d jobs", done_total, ROWS));
    assert (rd_total == ROWS * `XCR_BLOCK_WORDS && wr_total == ROWS * `XCR_BLOCK_WORDS)
      else flag_error($sformatf("%0d reads and %0d writes in total", rd_total, wr_total));
    $display("Errors: %0d", error_cnt);
    if (error_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* hw/xcr_top.sv */
`timescale 1ns/1ps

module xcr_top (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start_i,
  input  xcr_data_pkg::addr_t  src_addr_i,
  input  xcr_data_pkg::addr_t  dst_addr_i,
  input  xcr_data_pkg::key_t   key_i,
  input  xcr_data_pkg::word_t  rd_data_i,
  output logic                 done_o,
  output logic                 rd_req_o,
  output logic                 wr_en_o,
  output xcr_data_pkg::addr_t  rd_addr_o,
  output xcr_data_pkg::addr_t  wr_addr_o,
  output xcr_data_pkg::word_t  wr_data_o
);

  logic                    fetch;
  logic                    fetch_done;
  logic                    run;
  logic                    busy;
  logic                    store;
  logic                    store_done;
  logic                    clear;
  xcr_ctrl_pkg::word_idx_t word_idx;
  xcr_data_pkg::block_t    in_block;
  xcr_data_pkg::block_t    out_block;

  xcr_fsm u_fsm (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_i      (start_i),
    .fetch_done_i (fetch_done),
    .busy_i       (busy),
    .store_done_i (store_done),
    .fetch_o      (fetch),
    .run_o        (run),
    .store_o      (store),
    .clear_o      (clear),
    .done_o       (done_o),
    .word_idx_o   (word_idx)
  );

  word_reader u_reader (
    .clk          (clk),
    .reset_n      (reset_n),
    .fetch_i      (fetch),
    .word_idx_i   (word_idx),
    .src_addr_i   (src_addr_i),
    .rd_data_i    (rd_data_i),
    .rd_req_o     (rd_req_o),
    .fetch_done_o (fetch_done),
    .rd_addr_o    (rd_addr_o),
    .block_o      (in_block)
  );

  mix_engine u_engine (
    .clk     (clk),
    .reset_n (reset_n),
    .clear_i (clear),
    .run_i   (run),
    .block_i (in_block),
    .key_i   (key_i),
    .busy_o  (busy),
    .block_o (out_block)
  );

  word_writer u_writer (
    .clk          (clk),
    .reset_n      (reset_n),
    .store_i      (store),
    .word_idx_i   (word_idx),
    .dst_addr_i   (dst_addr_i),
    .block_i      (out_block),
    .wr_en_o      (wr_en_o),
    .store_done_o (store_done),
    .wr_addr_o    (wr_addr_o),
    .wr_data_o    (wr_data_o)
  );

endmodule

/* hw/word_writer.sv */
`timescale 1ns/1ps
`include "xcr_settings.svh"

module word_writer (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    store_i,
  input  xcr_ctrl_pkg::word_idx_t word_idx_i,
  input  xcr_data_pkg::addr_t     dst_addr_i,
  input  xcr_data_pkg::block_t    block_i,
  output logic                    wr_en_o,
  output logic                    store_done_o,
  output xcr_data_pkg::addr_t     wr_addr_o,
  output xcr_data_pkg::word_t     wr_data_o
);

  logic                wr_q;
  xcr_data_pkg::addr_t addr_q;
  xcr_data_pkg::word_t data_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      wr_q <= 1'b0;
    else
      wr_q <= store_i;
  end

  // Address and word captured on the request
  always_ff @(posedge clk) begin
    if (store_i) begin
      addr_q <= dst_addr_i
              + xcr_data_pkg::addr_t'(word_idx_i) * (`XCR_WORD_W / 8);
      data_q <= block_i[word_idx_i];
    end
  end

  // Write completes in the strobe cycle
  assign wr_en_o      = wr_q;
  assign store_done_o = wr_q;
  assign wr_addr_o    = addr_q;
  assign wr_data_o    = data_q;

endmodule

/* hw/mix_engine.sv */
`timescale 1ns/1ps
`include "xcr_settings.svh"

module mix_engine (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 clear_i,
  input  logic                 run_i,
  input  xcr_data_pkg::block_t block_i,
  input  xcr_data_pkg::key_t   key_i,
  output logic                 busy_o,
  output xcr_data_pkg::block_t block_o
);

  localparam int BLOCK_W = $bits(xcr_data_pkg::block_t);
  localparam int CNT_W   = $clog2(`XCR_ROUNDS + 1);

  logic [CNT_W-1:0]     rnd_cnt;
  xcr_data_pkg::block_t state_q;

  // One round: key XOR, then rotate the block left by one bit
  function automatic xcr_data_pkg::block_t mix_round(
    input xcr_data_pkg::block_t b,
    input xcr_data_pkg::key_t   k
  );
    logic [BLOCK_W-1:0] flat;
    flat = b ^ k;
    return {flat[BLOCK_W-2:0], flat[BLOCK_W-1]};
  endfunction

  // First round is applied while loading
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      rnd_cnt <= '0;
    else if (clear_i)
      rnd_cnt <= '0;
    else if (run_i)
      rnd_cnt <= CNT_W'(1);
    else if (rnd_cnt == CNT_W'(`XCR_ROUNDS - 1))
      rnd_cnt <= '0;
    else if (rnd_cnt != '0)
      rnd_cnt <= rnd_cnt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (clear_i)
      state_q <= '0;
    else if (run_i)
      state_q <= mix_round(block_i, key_i);
    else if (rnd_cnt != '0)
      state_q <= mix_round(state_q, key_i);
  end

  assign busy_o  = (rnd_cnt != '0);
  assign block_o = state_q;

  // Controller waits for the result before starting again
  a_run_not_busy: assert property (
    @(posedge clk) disable iff (!reset_n) run_i |-> !busy_o
  );

endmodule

/* hw/word_reader.sv */
`timescale 1ns/1ps
`include "xcr_settings.svh"

module word_reader (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    fetch_i,
  input  xcr_ctrl_pkg::word_idx_t word_idx_i,
  input  xcr_data_pkg::addr_t     src_addr_i,
  input  xcr_data_pkg::word_t     rd_data_i,
  output logic                    rd_req_o,
  output logic                    fetch_done_o,
  output xcr_data_pkg::addr_t     rd_addr_o,
  output xcr_data_pkg::block_t    block_o
);

  logic                    pend_valid;
  xcr_ctrl_pkg::word_idx_t pend_idx;
  xcr_data_pkg::block_t    block_q;

  // Request goes out in the fetch cycle itself
  assign rd_req_o  = fetch_i;
  assign rd_addr_o = src_addr_i
                   + xcr_data_pkg::addr_t'(word_idx_i) * (`XCR_WORD_W / 8);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      pend_valid <= 1'b0;
    else
      pend_valid <= fetch_i;
  end

  always_ff @(posedge clk) begin
    if (fetch_i)
      pend_idx <= word_idx_i;
  end

  // Data returns one cycle after the request
  always_ff @(posedge clk) begin
    if (pend_valid)
      block_q[pend_idx] <= rd_data_i;
  end

  assign fetch_done_o = pend_valid;
  assign block_o      = block_q;

  // Memory latency allows only one read in flight
  a_no_overlap: assert property (
    @(posedge clk) disable iff (!reset_n) pend_valid |-> !fetch_i
  );

endmodule

/* hw/xcr_fsm.sv */
`timescale 1ns/1ps
`include "xcr_settings.svh"

module xcr_fsm (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    start_i,
  input  logic                    fetch_done_i,
  input  logic                    busy_i,
  input  logic                    store_done_i,
  output logic                    fetch_o,
  output logic                    run_o,
  output logic                    store_o,
  output logic                    clear_o,
  output logic                    done_o,
  output xcr_ctrl_pkg::word_idx_t word_idx_o
);

  xcr_ctrl_pkg::xcr_state_t current_state, next_state;
  xcr_ctrl_pkg::word_idx_t  word_cnt;
  logic                     run_issued;
  logic                     last_word;

  assign last_word  = (word_cnt == xcr_ctrl_pkg::word_idx_t'(`XCR_BLOCK_WORDS - 1));
  assign word_idx_o = word_cnt;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      current_state <= xcr_ctrl_pkg::IDLE;
    else
      current_state <= next_state;
  end

  // Word counter wraps to zero after the last word of a pass
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      word_cnt <= '0;
    else if (run_o || clear_o)
      word_cnt <= '0;
    else if (fetch_done_i || store_done_i)
      word_cnt <= word_cnt + 1'b1;
  end

  // Engine gets exactly one run per job
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      run_issued <= 1'b0;
    else if (clear_o)
      run_issued <= 1'b0;
    else if (run_o)
      run_issued <= 1'b1;
  end

  always_comb begin
    next_state = current_state;
    case (current_state)
      xcr_ctrl_pkg::IDLE: begin
        if (start_i)
          next_state = xcr_ctrl_pkg::STARTING;
      end
      xcr_ctrl_pkg::STARTING: begin
        next_state = xcr_ctrl_pkg::FETCH;
      end
      xcr_ctrl_pkg::FETCH: begin
        next_state = xcr_ctrl_pkg::FETCH_WAIT;
      end
      xcr_ctrl_pkg::FETCH_WAIT: begin
        if (fetch_done_i)
          next_state = last_word ? xcr_ctrl_pkg::WORKING : xcr_ctrl_pkg::FETCH;
      end
      xcr_ctrl_pkg::WORKING: begin
        // Busy only rises after the run cycle
        if (run_issued && !busy_i)
          next_state = xcr_ctrl_pkg::STORE;
      end
      xcr_ctrl_pkg::STORE: begin
        next_state = xcr_ctrl_pkg::STORE_WAIT;
      end
      xcr_ctrl_pkg::STORE_WAIT: begin
        if (store_done_i)
          next_state = last_word ? xcr_ctrl_pkg::FINISHED : xcr_ctrl_pkg::STORE;
      end
      xcr_ctrl_pkg::FINISHED: begin
        next_state = xcr_ctrl_pkg::IDLE;
      end
      default: begin
        next_state = xcr_ctrl_pkg::IDLE;
      end
    endcase
  end

  always_comb begin
    fetch_o = (current_state == xcr_ctrl_pkg::FETCH);
    store_o = (current_state == xcr_ctrl_pkg::STORE);
    clear_o = (current_state == xcr_ctrl_pkg::IDLE);
    done_o  = (current_state == xcr_ctrl_pkg::FINISHED);
    run_o   = (current_state == xcr_ctrl_pkg::WORKING) && !run_issued;
  end

  // Completions only arrive in the matching wait state
  a_fetch_done_in_wait: assert property (
    @(posedge clk) disable iff (!reset_n)
    fetch_done_i |-> (current_state == xcr_ctrl_pkg::FETCH_WAIT)
  );

  a_store_done_in_wait: assert property (
    @(posedge clk) disable iff (!reset_n)
    store_done_i |-> (current_state == xcr_ctrl_pkg::STORE_WAIT)
  );

endmodule

/* hw/xcr_data_pkg.sv */
`include "xcr_settings.svh"

package xcr_data_pkg;

  typedef logic [`XCR_WORD_W-1:0] word_t;

  // Word 0 is the least significant and the lowest address
  typedef logic [`XCR_BLOCK_WORDS-1:0][`XCR_WORD_W-1:0] block_t;

  // Byte address on the memory port
  typedef logic [31:0] addr_t;

  typedef logic [`XCR_BLOCK_WORDS*`XCR_WORD_W-1:0] key_t;

endpackage

/* hw/xcr_ctrl_pkg.sv */
`include "xcr_settings.svh"

package xcr_ctrl_pkg;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,
    STARTING,
    FETCH,
    FETCH_WAIT,
    WORKING,
    STORE,
    STORE_WAIT,
    FINISHED
  } xcr_state_t;

  // Selects one word of a block
  typedef logic [$clog2(`XCR_BLOCK_WORDS)-1:0] word_idx_t;

endpackage

/* hw/xcr_settings.svh */
`ifndef XCR_SETTINGS_SVH
`define XCR_SETTINGS_SVH

// Memory word width in bits
`define XCR_WORD_W 32

// Words in one transform block
`define XCR_BLOCK_WORDS 4

// Engine rounds applied per block, one per clock
`define XCR_ROUNDS 4

`endif
